/* hdl/mips_pkg.sv */
// shared types and constants; big-endian byte order, register 0 hardwired to zero by the regfile.
package mips_pkg;

    // ----------------------------------------------------------------------
    // basic datapath types
    // ----------------------------------------------------------------------

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // one bit per byte lane, bit 3 is bits 31:24.
    typedef logic [3:0]  byteen_t;

    // ----------------------------------------------------------------------
    // register numbers and constants
    // ----------------------------------------------------------------------

    localparam int        NUM_REGS    = 32;
    localparam int        REG_V0      = 2;
    localparam reg_addr_t REG_RA      = 5'd31;

    // return address sits past the delay slot.
    localparam word_t     LINK_OFFSET = 32'd8;

    // all four lanes written.
    localparam byteen_t   BE_FULL     = 4'b1111;

    // ----------------------------------------------------------------------
    // opcodes
    // ----------------------------------------------------------------------

    typedef enum logic [2:0] {
        ADDU = 3'd0,
        SUBU = 3'd1,
        AND  = 3'd2,
        OR   = 3'd3,
        XOR  = 3'd4,
        NOR  = 3'd5,
        SLT  = 3'd6,
        SLTU = 3'd7
    } alu_op_e;

    // code 7 is unused.
    typedef enum logic [2:0] {
        LB  = 3'd0,
        LBU = 3'd1,
        LH  = 3'd2,
        LHU = 3'd3,
        LW  = 3'd4,
        LWL = 3'd5,
        LWR = 3'd6
    } ld_op_e;

endpackage

/* hdl/wb_req_if.sv */
// one register-write request; payload must stay stable while valid is high and ready is low.
`timescale 1ns/1ps

interface wb_req_if;

    logic                valid;
    logic                ready;
    mips_pkg::reg_addr_t addr;
    mips_pkg::word_t     data;
    mips_pkg::byteen_t   byteen;

    // request producer.
    modport src (output valid, addr, data, byteen, input ready);

    // arbiter side of a source.
    modport arb (input valid, addr, data, byteen, output ready);

    // register file never stalls, so no ready here.
    modport rf (input valid, addr, data, byteen);

endinterface

/* hdl/regfile.sv */
// 32x32 register file; reads are combinational and show the value before this edge's write.
`timescale 1ns/1ps

module regfile (
    input  logic                clk,
    input  logic                rst,
    input  mips_pkg::reg_addr_t rs_addr,
    input  mips_pkg::reg_addr_t rt_addr,
    output mips_pkg::word_t     rs_data,
    output mips_pkg::word_t     rt_data,
    wb_req_if.rf                wr,
    output mips_pkg::word_t     v0
);

    localparam int NUM_LANES = $bits(mips_pkg::byteen_t);

    mips_pkg::word_t regs [mips_pkg::NUM_REGS];

    // ----------------------------------------------------------------------
    // read ports
    // ----------------------------------------------------------------------

    // register 0 reads as zero whatever is stored.
    always_comb begin
        if (rs_addr == '0) begin
            rs_data = '0;
        end else begin
            rs_data = regs[rs_addr];
        end
        if (rt_addr == '0) begin
            rt_data = '0;
        end else begin
            rt_data = regs[rt_addr];
        end
    end

    assign v0 = regs[mips_pkg::REG_V0];

    // ----------------------------------------------------------------------
    // write port
    // ----------------------------------------------------------------------

    // only enabled lanes change, writes to r0 are dropped.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < mips_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.valid && wr.addr != '0) begin
            for (int lane = 0; lane < NUM_LANES; lane++) begin
                if (wr.byteen[lane]) begin
                    regs[wr.addr][8*lane +: 8] <= wr.data[8*lane +: 8];
                end
            end
        end
    end

    // ----------------------------------------------------------------------
    // checks
    // ----------------------------------------------------------------------

    // every writer upstream must produce one of the load or full-word masks.
    property p_legal_byteen;
        @(posedge clk) disable iff (rst)
        wr.valid |-> wr.byteen inside {
            4'b0001, 4'b0010, 4'b0100, 4'b1000,
            4'b0011, 4'b0111, 4'b1100, 4'b1110,
            4'b1111
        };
    endproperty

    a_legal_byteen : assert property (p_legal_byteen)
        else $error("regfile: illegal byte enable %b on write to r%0d",
                    wr.byteen, wr.addr);

endmodule

/* hdl/alu_stage.sv */
// one-stage ALU; no shifts, multiply or divide, arithmetic wraps and never traps.
`timescale 1ns/1ps

module alu_stage (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_valid,
    output logic                in_ready,
    input  mips_pkg::alu_op_e   op,
    input  mips_pkg::reg_addr_t rd,
    input  mips_pkg::word_t     a,
    input  mips_pkg::word_t     b,
    wb_req_if.src               out
);

    mips_pkg::word_t     result;
    logic                valid_q;
    mips_pkg::word_t     result_q;
    mips_pkg::reg_addr_t rd_q;
    logic                accept;

    // ----------------------------------------------------------------------
    // combinational result
    // ----------------------------------------------------------------------

    always_comb begin
        case (op)
            mips_pkg::ADDU: result = a + b;
            mips_pkg::SUBU: result = a - b;
            mips_pkg::AND:  result = a & b;
            mips_pkg::OR:   result = a | b;
            mips_pkg::XOR:  result = a ^ b;
            mips_pkg::NOR:  result = ~(a | b);
            // set-less-than, signed and unsigned.
            mips_pkg::SLT:  result = {31'b0, $signed(a) < $signed(b)};
            mips_pkg::SLTU: result = {31'b0, a < b};
            default:        result = '0;
        endcase
    end

    // ----------------------------------------------------------------------
    // output register
    // ----------------------------------------------------------------------

    // a new op can enter while the held result leaves.
    assign in_ready = !valid_q || out.ready;
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (accept) begin
            valid_q <= 1'b1;
        end else if (out.ready) begin
            valid_q <= 1'b0;
        end
    end

    // payload only.
    always_ff @(posedge clk) begin
        if (accept) begin
            result_q <= result;
            rd_q     <= rd;
        end
    end

    assign out.valid  = valid_q;
    assign out.addr   = rd_q;
    assign out.data   = result_q;
    assign out.byteen = mips_pkg::BE_FULL;

    // ----------------------------------------------------------------------
    // checks
    // ----------------------------------------------------------------------

    // stalled result must survive until the arbiter takes it.
    a_hold_stable : assert property (
        @(posedge clk) disable iff (rst)
        out.valid && !out.ready |=> out.valid && $stable(out.data) && $stable(out.addr)
    ) else $error("alu_stage: held result changed while stalled");

endmodule

/* hdl/load_align.sv */
// big-endian load aligner; misaligned LH, LHU and LW are caller errors and are not trapped.
`timescale 1ns/1ps

module load_align (
    input  logic                ld_valid,
    output logic                ld_ready,
    input  mips_pkg::ld_op_e    op,
    input  mips_pkg::reg_addr_t rt,
    input  logic [1:0]          offset,
    input  mips_pkg::word_t     mem_data,
    wb_req_if.src               out
);

    logic [7:0]      sel_byte;
    logic [15:0]     sel_half;
    logic [4:0]      shift_l;
    logic [4:0]      shift_r;
    mips_pkg::word_t data;
    mips_pkg::byteen_t byteen;

    // ----------------------------------------------------------------------
    // lane selection
    // ----------------------------------------------------------------------

    // byte k of the word lives in lane 3 - k.
    assign sel_byte = mem_data[{~offset, 3'b000} +: 8];
    assign sel_half = offset[1] ? mem_data[15:0] : mem_data[31:16];

    // lwl moves byte k to the top, lwr moves byte k to the bottom.
    assign shift_l = {offset, 3'b000};
    assign shift_r = {~offset, 3'b000};

    always_comb begin
        byteen = mips_pkg::BE_FULL;
        case (op)
            mips_pkg::LB:  data = {{24{sel_byte[7]}}, sel_byte};
            mips_pkg::LBU: data = {24'b0, sel_byte};
            mips_pkg::LH:  data = {{16{sel_half[15]}}, sel_half};
            mips_pkg::LHU: data = {16'b0, sel_half};
            mips_pkg::LWL: begin
                data   = mem_data << shift_l;
                byteen = mips_pkg::BE_FULL << offset;
            end
            mips_pkg::LWR: begin
                data   = mem_data >> shift_r;
                byteen = mips_pkg::BE_FULL >> ~offset;
            end
            default:       data = mem_data;
        endcase
    end

    // ----------------------------------------------------------------------
    // request
    // ----------------------------------------------------------------------

    assign out.valid  = ld_valid;
    assign out.addr   = rt;
    assign out.data   = data;
    assign out.byteen = byteen;
    assign ld_ready   = out.ready;

    // ----------------------------------------------------------------------
    // checks
    // ----------------------------------------------------------------------

    // address alignment is decode's job.
    always_comb begin
        if (ld_valid) begin
            a_aligned : assert final (
                !((op == mips_pkg::LH || op == mips_pkg::LHU) && offset[0]) &&
                !(op == mips_pkg::LW && offset != 2'b00)
            ) else $error("load_align: %s at misaligned offset %0d", op.name(), offset);
        end
    end

endmodule

/* hdl/wb_arbiter.sv */
// fixed-priority writeback arbiter, alu over load over link; one write per cycle.
`timescale 1ns/1ps

module wb_arbiter (
    wb_req_if.arb               alu,
    wb_req_if.arb               ld,
    input  logic                link_valid,
    output logic                link_ready,
    input  logic                link,
    input  mips_pkg::reg_addr_t link_rd,
    input  mips_pkg::word_t     link_pc,
    wb_req_if.src               wr
);

    mips_pkg::reg_addr_t link_addr;
    mips_pkg::word_t     link_data;

    // ----------------------------------------------------------------------
    // grants
    // ----------------------------------------------------------------------

    assign alu.ready  = wr.ready;
    assign ld.ready   = wr.ready && !alu.valid;
    assign link_ready = wr.ready && !alu.valid && !ld.valid;

    // ----------------------------------------------------------------------
    // link request
    // ----------------------------------------------------------------------

    // jal/jalr style, r31 or rd.
    assign link_addr = link ? mips_pkg::REG_RA : link_rd;
    assign link_data = link_pc + mips_pkg::LINK_OFFSET;

    // ----------------------------------------------------------------------
    // write port mux
    // ----------------------------------------------------------------------

    always_comb begin
        wr.valid = alu.valid || ld.valid || link_valid;
        if (alu.valid) begin
            wr.addr   = alu.addr;
            wr.data   = alu.data;
            wr.byteen = alu.byteen;
        end else if (ld.valid) begin
            wr.addr   = ld.addr;
            wr.data   = ld.data;
            wr.byteen = ld.byteen;
        end else begin
            wr.addr   = link_addr;
            wr.data   = link_data;
            wr.byteen = mips_pkg::BE_FULL;
        end
    end

    // only one source may transfer per cycle.
    always_comb begin
        a_one_grant : assert final ($onehot0({alu.valid && alu.ready,
                                              ld.valid && ld.ready,
                                              link_valid && link_ready}))
            else $error("wb_arbiter: more than one source granted");
    end

endmodule

/* hdl/reg_wb_top.sv */
// writeback slice top; alu operands always come from the rs/rt read ports.
`timescale 1ns/1ps

module reg_wb_top (
    input  logic                clk,
    input  logic                rst,
    // alu issue.
    input  logic                alu_valid,
    output logic                alu_ready,
    input  mips_pkg::alu_op_e   alu_op,
    input  mips_pkg::reg_addr_t alu_rs,
    input  mips_pkg::reg_addr_t alu_rt,
    input  mips_pkg::reg_addr_t alu_rd,
    output mips_pkg::word_t     rs_data,
    output mips_pkg::word_t     rt_data,
    // load return.
    input  logic                ld_valid,
    output logic                ld_ready,
    input  mips_pkg::ld_op_e    ld_op,
    input  mips_pkg::reg_addr_t ld_rt,
    input  logic [1:0]          ld_offset,
    input  mips_pkg::word_t     ld_mem_data,
    // link write.
    input  logic                link_valid,
    output logic                link_ready,
    input  logic                link,
    input  mips_pkg::reg_addr_t link_rd,
    input  mips_pkg::word_t     link_pc,
    output mips_pkg::word_t     v0
);

    wb_req_if alu_req ();
    wb_req_if ld_req ();
    wb_req_if wr_port ();

    // register file takes a write every cycle.
    assign wr_port.ready = 1'b1;

    regfile u_regfile (
        .clk     (clk),
        .rst     (rst),
        .rs_addr (alu_rs),
        .rt_addr (alu_rt),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .wr      (wr_port.rf),
        .v0      (v0)
    );

    alu_stage u_alu_stage (
        .clk      (clk),
        .rst      (rst),
        .in_valid (alu_valid),
        .in_ready (alu_ready),
        .op       (alu_op),
        .rd       (alu_rd),
        .a        (rs_data),
        .b        (rt_data),
        .out      (alu_req.src)
    );

    load_align u_load_align (
        .ld_valid (ld_valid),
        .ld_ready (ld_ready),
        .op       (ld_op),
        .rt       (ld_rt),
        .offset   (ld_offset),
        .mem_data (ld_mem_data),
        .out      (ld_req.src)
    );

    wb_arbiter u_wb_arbiter (
        .alu        (alu_req.arb),
        .ld         (ld_req.arb),
        .link_valid (link_valid),
        .link_ready (link_ready),
        .link       (link),
        .link_rd    (link_rd),
        .link_pc    (link_pc),
        .wr         (wr_port.src)
    );

endmodule

/* tests/tb_top.sv */
// directed testbench for reg_wb_top; every handshake wait gives up after 50 cycles.
`timescale 1ns/1ps

module tb_top;

    logic                clk;
    logic                rst;
    logic                alu_valid;
    logic                alu_ready;
    mips_pkg::alu_op_e   alu_op;
    mips_pkg::reg_addr_t alu_rs;
    mips_pkg::reg_addr_t alu_rt;
    mips_pkg::reg_addr_t alu_rd;
    mips_pkg::word_t     rs_data;
    mips_pkg::word_t     rt_data;
    logic                ld_valid;
    logic                ld_ready;
    mips_pkg::ld_op_e    ld_op;
    mips_pkg::reg_addr_t ld_rt;
    logic [1:0]          ld_offset;
    mips_pkg::word_t     ld_mem_data;
    logic                link_valid;
    logic                link_ready;
    logic                link;
    mips_pkg::reg_addr_t link_rd;
    mips_pkg::word_t     link_pc;
    mips_pkg::word_t     v0;

    mips_pkg::word_t model [mips_pkg::NUM_REGS];
    int              errors;
    int              timeout_cycles = 50;

    reg_wb_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ----------------------------------------------------------------------
    // reference model
    // ----------------------------------------------------------------------

    function automatic mips_pkg::word_t alu_model(input mips_pkg::alu_op_e op,
                                                  input mips_pkg::word_t a,
                                                  input mips_pkg::word_t b);
        case (op)
            mips_pkg::ADDU: return a + b;
            mips_pkg::SUBU: return a - b;
            mips_pkg::AND:  return a & b;
            mips_pkg::OR:   return a | b;
            mips_pkg::XOR:  return a ^ b;
            mips_pkg::NOR:  return ~(a | b);
            mips_pkg::SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default:        return (a < b) ? 32'd1 : 32'd0;
        endcase
    endfunction

    // merged register value after a load; byte k of mem is lane 3 - k.
    function automatic mips_pkg::word_t load_model(input mips_pkg::ld_op_e op,
                                                   input logic [1:0] off,
                                                   input mips_pkg::word_t mem,
                                                   input mips_pkg::word_t old);
        mips_pkg::word_t   nw;
        mips_pkg::word_t   res;
        mips_pkg::byteen_t be;
        logic [7:0]        b;
        logic [15:0]       h;
        b  = mem[31 - 8*off -: 8];
        h  = (off == 2'd0) ? mem[31:16] : mem[15:0];
        be = 4'b1111;
        case (op)
            mips_pkg::LB:  nw = {{24{b[7]}}, b};
            mips_pkg::LBU: nw = {24'd0, b};
            mips_pkg::LH:  nw = {{16{h[15]}}, h};
            mips_pkg::LHU: nw = {16'd0, h};
            mips_pkg::LWL: begin
                nw = mem << (8*off);
                be = (off == 0) ? 4'b1111 : (off == 1) ? 4'b1110 :
                     (off == 2) ? 4'b1100 : 4'b1000;
            end
            mips_pkg::LWR: begin
                nw = mem >> (8*(3 - off));
                be = (off == 3) ? 4'b1111 : (off == 2) ? 4'b0111 :
                     (off == 1) ? 4'b0011 : 4'b0001;
            end
            default:       nw = mem;
        endcase
        for (int lane = 0; lane < 4; lane++) begin
            res[8*lane +: 8] = be[lane] ? nw[8*lane +: 8] : old[8*lane +: 8];
        end
        return res;
    endfunction

    function automatic void write_model(input mips_pkg::reg_addr_t addr,
                                        input mips_pkg::word_t data);
        if (addr != 5'd0) model[addr] = data;
    endfunction

    // ----------------------------------------------------------------------
    // compare tasks
    // ----------------------------------------------------------------------

    task automatic check_word(input string name, input mips_pkg::word_t got,
                              input mips_pkg::word_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%08h expected 0x%08h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    // reads through both ports.
    task automatic check_reg(input mips_pkg::reg_addr_t addr);
        @(posedge clk);
        alu_rs <= addr;
        alu_rt <= addr;
        @(negedge clk);
        check_word($sformatf("rs_data[r%0d]", addr), rs_data, model[addr]);
        check_word($sformatf("rt_data[r%0d]", addr), rt_data, model[addr]);
    endtask

    // ----------------------------------------------------------------------
    // drive and handshake tasks
    // ----------------------------------------------------------------------

    // drive_* tasks are called right after a rising edge.
    task automatic drive_alu(input mips_pkg::alu_op_e op, input mips_pkg::reg_addr_t rs,
                             input mips_pkg::reg_addr_t rt, input mips_pkg::reg_addr_t rd);
        alu_valid <= 1'b1;
        alu_op    <= op;
        alu_rs    <= rs;
        alu_rt    <= rt;
        alu_rd    <= rd;
    endtask

    task automatic drive_ld(input mips_pkg::ld_op_e op, input mips_pkg::reg_addr_t rt,
                            input logic [1:0] off, input mips_pkg::word_t mem);
        ld_valid    <= 1'b1;
        ld_op       <= op;
        ld_rt       <= rt;
        ld_offset   <= off;
        ld_mem_data <= mem;
    endtask

    task automatic drive_link(input logic lk, input mips_pkg::reg_addr_t rd,
                              input mips_pkg::word_t pc);
        link_valid <= 1'b1;
        link       <= lk;
        link_rd    <= rd;
        link_pc    <= pc;
    endtask

    // starts at a falling edge and returns just after the accepting edge.
    task automatic wait_alu(input bit drop);
        int n;
        n = 0;
        while (!alu_ready && n < timeout_cycles) begin
            @(negedge clk);
            n++;
        end
        if (!alu_ready) begin
            $display("timeout: alu_ready stayed low for %0d cycles", n);
            errors++;
        end else begin
            write_model(alu_rd, alu_model(alu_op, model[alu_rs], model[alu_rt]));
        end
        @(posedge clk);
        if (drop) alu_valid <= 1'b0;
    endtask

    task automatic wait_ld();
        int n;
        n = 0;
        while (!ld_ready && n < timeout_cycles) begin
            @(negedge clk);
            n++;
        end
        if (!ld_ready) begin
            $display("timeout: ld_ready stayed low for %0d cycles", n);
            errors++;
        end else begin
            write_model(ld_rt, load_model(ld_op, ld_offset, ld_mem_data, model[ld_rt]));
        end
        @(posedge clk);
        ld_valid <= 1'b0;
    endtask

    task automatic wait_link();
        int n;
        n = 0;
        while (!link_ready && n < timeout_cycles) begin
            @(negedge clk);
            n++;
        end
        if (!link_ready) begin
            $display("timeout: link_ready stayed low for %0d cycles", n);
            errors++;
        end else begin
            write_model(link ? mips_pkg::REG_RA : link_rd, link_pc + 32'd8);
        end
        @(posedge clk);
        link_valid <= 1'b0;
    endtask

    task automatic run_alu(input mips_pkg::alu_op_e op, input mips_pkg::reg_addr_t rs,
                           input mips_pkg::reg_addr_t rt, input mips_pkg::reg_addr_t rd);
        @(posedge clk);
        drive_alu(op, rs, rt, rd);
        @(negedge clk);
        wait_alu(1'b1);
    endtask

    task automatic do_load(input mips_pkg::ld_op_e op, input mips_pkg::reg_addr_t rt,
                           input logic [1:0] off, input mips_pkg::word_t mem);
        @(posedge clk);
        drive_ld(op, rt, off, mem);
        @(negedge clk);
        wait_ld();
    endtask

    task automatic do_link(input logic lk, input mips_pkg::reg_addr_t rd,
                           input mips_pkg::word_t pc);
        @(posedge clk);
        drive_link(lk, rd, pc);
        @(negedge clk);
        wait_link();
    endtask

    task automatic reapply_reset();
        @(posedge clk);
        rst <= 1'b1;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < mips_pkg::NUM_REGS; i++) begin
            model[i] = 32'd0;
        end
    endtask

    // ----------------------------------------------------------------------
    // directed tests
    // ----------------------------------------------------------------------

    task automatic reset_values();
        for (int i = 0; i < mips_pkg::NUM_REGS; i++) begin
            check_reg(mips_pkg::reg_addr_t'(i));
        end
        check_word("v0", v0, 32'd0);
    endtask

    task automatic alu_ops();
        do_load(mips_pkg::LW, 5'd8, 2'd0, $urandom());
        do_load(mips_pkg::LW, 5'd9, 2'd0, $urandom());
        for (int i = 0; i < 8; i++) begin
            run_alu(mips_pkg::alu_op_e'(i), 5'd8, 5'd9, mips_pkg::reg_addr_t'(10 + i));
            check_reg(mips_pkg::reg_addr_t'(10 + i));
        end
        // r0 must stay zero.
        run_alu(mips_pkg::OR, 5'd8, 5'd9, 5'd0);
        check_reg(5'd0);
        run_alu(mips_pkg::ADDU, 5'd8, 5'd9, 5'd2);
        check_reg(5'd2);
        check_word("v0", v0, model[2]);
    endtask

    task automatic load_alignment();
        mips_pkg::ld_op_e op;
        for (int i = 0; i < 7; i++) begin
            op = mips_pkg::ld_op_e'(i);
            for (int off = 0; off < 4; off++) begin
                if ((op == mips_pkg::LH || op == mips_pkg::LHU) && off[0]) continue;
                if (op == mips_pkg::LW && off != 0) continue;
                // known background for the partial merges.
                do_load(mips_pkg::LW, 5'd12, 2'd0, $urandom());
                do_load(op, 5'd12, off[1:0], $urandom());
                check_reg(5'd12);
            end
        end
    endtask

    task automatic link_writes();
        do_link(1'b1, 5'd7, $urandom());
        check_reg(mips_pkg::REG_RA);
        do_link(1'b0, 5'd6, $urandom());
        check_reg(5'd6);
    endtask

    task automatic priority_backpressure();
        @(posedge clk);
        drive_alu(mips_pkg::ADDU, 5'd8, 5'd9, 5'd14);
        drive_ld(mips_pkg::LW, 5'd15, 2'd0, $urandom());
        drive_link(1'b0, 5'd16, $urandom());
        @(negedge clk);
        check_flag("alu_ready", alu_ready, 1'b1);
        check_flag("ld_ready", ld_ready, 1'b1);
        check_flag("link_ready", link_ready, 1'b0);
        fork
            wait_alu(1'b1);
            wait_ld();
            wait_link();
        join
        check_reg(5'd14);
        check_reg(5'd15);
        check_reg(5'd16);
        // a load behind a held alu result waits for the port.
        run_alu(mips_pkg::AND, 5'd8, 5'd9, 5'd17);
        drive_ld(mips_pkg::LW, 5'd18, 2'd0, $urandom());
        @(negedge clk);
        check_flag("ld_ready", ld_ready, 1'b0);
        wait_ld();
        check_reg(5'd17);
        check_reg(5'd18);
    endtask

    task automatic back_to_back_alu();
        @(posedge clk);
        drive_alu(mips_pkg::SUBU, 5'd8, 5'd9, 5'd20);
        @(negedge clk);
        check_flag("alu_ready", alu_ready, 1'b1);
        wait_alu(1'b0);
        // second op enters while the first result is still held.
        drive_alu(mips_pkg::XOR, 5'd8, 5'd9, 5'd21);
        @(negedge clk);
        check_flag("alu_ready", alu_ready, 1'b1);
        wait_alu(1'b1);
        check_reg(5'd20);
        check_reg(5'd21);
    endtask

    // ----------------------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------------------

    initial begin
        void'($urandom(86302));
        errors      = 0;
        rst         = 1'b1;
        alu_valid   = 1'b0;
        alu_op      = mips_pkg::ADDU;
        alu_rs      = 5'd0;
        alu_rt      = 5'd0;
        alu_rd      = 5'd0;
        ld_valid    = 1'b0;
        ld_op       = mips_pkg::LW;
        ld_rt       = 5'd0;
        ld_offset   = 2'd0;
        ld_mem_data = 32'd0;
        link_valid  = 1'b0;
        link        = 1'b0;
        link_rd     = 5'd0;
        link_pc     = 32'd0;
        for (int i = 0; i < mips_pkg::NUM_REGS; i++) begin
            model[i] = 32'd0;
        end
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        reset_values();
        alu_ops();
        load_alignment();
        link_writes();
        priority_backpressure();
        back_to_back_alu();

        // reset again with many registers holding data.
        reapply_reset();
        reset_values();

        $display("run complete, %0d errors", errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* sim.f */
hdl/mips_pkg.sv
hdl/wb_req_if.sv
hdl/regfile.sv
hdl/alu_stage.sv
hdl/load_align.sv
hdl/wb_arbiter.sv
hdl/reg_wb_top.sv
tests/tb_top.sv

/* Makefile */
TOP := tb_top

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --assert -j 0 --top-module $(TOP) -f sim.f -o V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir
